/* project.f */
verilog/fetch_pkg.sv
verilog/fetch_pc_stage.sv
verilog/icache.sv
verilog/inst_decode_stage.sv
verilog/fetch_top.sv
verification/axi_mem_model.sv
verification/fetch_tb.sv

/* Makefile */
TOP = fetch_tb

sim:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) \
		-f project.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* verification/fetch_tb.sv */
`timescale 1ns/1ns

module fetch_tb;

    localparam int          line_count = 16;
    localparam int          wait_limit = 200;
    localparam logic [31:0] loop_base  = 32'h3000_1000;

    typedef struct packed {
        fetch_pkg::inst_format_t fmt;
        logic [6:0]              opcode;
        logic [4:0]              rd;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic [2:0]              funct3;
        logic [6:0]              funct7;
        logic [31:0]             imm;
    } decoded_t;

    logic                    clock;
    logic                    reset;
    logic [31:0]             redirect_pc;
    logic                    redirect_valid;
    logic                    clear_req;
    logic                    out_ready;
    logic                    arready;
    logic                    arvalid;
    logic [31:0]             araddr;
    logic [3:0]              arid;
    logic [7:0]              arlen;
    logic [2:0]              arsize;
    logic [1:0]              arburst;
    logic                    rready;
    logic                    rvalid;
    logic [31:0]             rdata;
    logic [1:0]              rresp;
    logic                    rlast;
    logic [3:0]              rid;
    logic                    out_valid;
    logic [31:0]             pc;
    logic [31:0]             inst;
    fetch_pkg::inst_format_t format;
    logic [6:0]              opcode;
    logic [4:0]              rd;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [31:0]             imm;
    logic [31:0]             lookup_addr;
    logic [31:0]             lookup_data;

    // Reference state of the comparison process
    logic [31:0]             expected_pc;
    logic                    ref_held;
    logic [31:0]             ref_held_pc;
    logic                    was_stalled;
    logic [31:0]             stall_pc;
    logic [31:0]             stall_inst;
    logic [31:0]             stall_imm;
    fetch_pkg::inst_format_t stall_format;
    logic [31:0]             want_word;
    decoded_t                want;
    int unsigned             ar_count;
    int unsigned             accept_count;
    int unsigned             taken;
    int unsigned             pass_start;
    int unsigned             want_handshakes;

    fetch_top #(
        .reset_pc   (fetch_pkg::reset_vector),
        .line_count (line_count)
    ) dut0 (.*);

    axi_mem_model mem0 (.*);

    assign lookup_data = mem_word(lookup_addr);

    always #50 clock = ~clock;

    // --------------------------------------------------
    // Memory contents and reference decode
    // --------------------------------------------------
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        h  = (addr ^ (addr >> 11)) * 32'h9e37_79b1;
        f3 = h[14:12];
        f7 = h[31:25];
        case (addr[5:2])
            4'd0: op = fetch_pkg::op_lui;
            4'd1: op = fetch_pkg::op_auipc;
            4'd2: op = fetch_pkg::op_jal;
            4'd3: begin
                op = fetch_pkg::op_jalr;
                f3 = 3'd0;
            end
            4'd4: begin
                op    = fetch_pkg::op_branch;
                f3[1] = h[13] & h[14];
            end
            4'd5: begin
                op    = fetch_pkg::op_load;
                f3[1] = 1'b0;
            end
            4'd6: begin
                op = fetch_pkg::op_store;
                f3 = {1'b0, h[13] & ~h[12], h[12]};
            end
            4'd7: begin
                op = fetch_pkg::op_reg;
                f7 = {1'b0, h[30] && !f3[1] && (f3[2] == f3[0]), 5'd0};
            end
            4'd8: begin
                op = fetch_pkg::op_system;
                f3 = {h[14], 2'b01};
            end
            default: begin
                op    = fetch_pkg::op_imm;
                f3[0] = 1'b0;
            end
        endcase
        return {f7, h[24:20], h[19:15], f3, h[11:7], op};
    endfunction

    // Field positions and immediates as the RV32I spec lays them out
    function automatic decoded_t decode_ref(input fetch_pkg::inst_word_t word);
        logic [31:0] b;
        decoded_t    d;
        b        = word;
        d.opcode = b[6:0];
        d.rd     = b[11:7];
        d.funct3 = b[14:12];
        d.rs1    = b[19:15];
        d.rs2    = b[24:20];
        d.funct7 = b[31:25];
        case (b[6:0])
            fetch_pkg::op_lui, fetch_pkg::op_auipc: d.fmt = fetch_pkg::fmt_u;
            fetch_pkg::op_jal:                      d.fmt = fetch_pkg::fmt_j;
            fetch_pkg::op_branch:                   d.fmt = fetch_pkg::fmt_b;
            fetch_pkg::op_store:                    d.fmt = fetch_pkg::fmt_s;
            fetch_pkg::op_reg:                      d.fmt = fetch_pkg::fmt_r;
            default:                                d.fmt = fetch_pkg::fmt_i;
        endcase
        case (d.fmt)
            fetch_pkg::fmt_r: d.imm = '0;
            fetch_pkg::fmt_s: d.imm = {{20{b[31]}}, b[31:25], b[11:7]};
            fetch_pkg::fmt_b: d.imm = {{19{b[31]}}, b[31], b[7], b[30:25], b[11:8], 1'b0};
            fetch_pkg::fmt_u: d.imm = {b[31:12], 12'd0};
            fetch_pkg::fmt_j: d.imm = {{11{b[31]}}, b[31], b[19:12], b[20], b[30:21], 1'b0};
            default:          d.imm = {{20{b[31]}}, b[31:20]};
        endcase
        return d;
    endfunction

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic stop_on_error(input string reason);
        $display("TEST FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error("Output value mismatch");
        end
    endtask

    // --------------------------------------------------
    // Comparison process, samples on the rising edge
    // --------------------------------------------------
    always @(posedge clock) begin
        if (reset) begin
            expected_pc  = fetch_pkg::reset_vector;
            ref_held     = 1'b0;
            was_stalled  = 1'b0;
            ar_count     = 0;
            accept_count = 0;
        end else begin
            if (arvalid && arready) begin
                ar_count++;
                // The fetch in flight is the next item expected
                check_value("araddr", araddr, expected_pc);
                check_value("arid", 32'(arid), 32'd0);
                check_value("arlen", 32'(arlen), 32'd0);
                check_value("arsize", 32'(arsize), 32'd2);
                check_value("arburst", 32'(arburst), 32'd0);
            end
            if (rvalid) begin
                check_value("rready", 32'(rready), 32'd1);
            end
            // Back-pressure freezes the decode outputs
            if (was_stalled) begin
                check_value("out_valid", 32'(out_valid), 32'd1);
                check_value("pc", pc, stall_pc);
                check_value("inst", inst, stall_inst);
                check_value("imm", imm, stall_imm);
                check_value("format", 32'(format), 32'(stall_format));
            end
            was_stalled  = out_valid && !out_ready;
            stall_pc     = pc;
            stall_inst   = inst;
            stall_imm    = imm;
            stall_format = format;
            if (out_valid && out_ready) begin
                want_word = mem_word(expected_pc);
                want      = decode_ref(want_word);
                check_value("pc", pc, expected_pc);
                check_value("inst", inst, want_word);
                check_value("format", 32'(format), 32'(want.fmt));
                check_value("opcode", 32'(opcode), 32'(want.opcode));
                check_value("rd", 32'(rd), 32'(want.rd));
                check_value("rs1", 32'(rs1), 32'(want.rs1));
                check_value("rs2", 32'(rs2), 32'(want.rs2));
                check_value("funct3", 32'(funct3), 32'(want.funct3));
                check_value("funct7", 32'(funct7), 32'(want.funct7));
                check_value("imm", imm, want.imm);
                accept_count++;
                if (ref_held) begin
                    expected_pc = ref_held_pc;
                end else if (redirect_valid) begin
                    expected_pc = redirect_pc;
                end else begin
                    expected_pc = expected_pc + 32'd4;
                end
                ref_held = 1'b0;
            end else if (redirect_valid && !ref_held) begin
                // First redirect outside an accept waits for the next one
                ref_held    = 1'b1;
                ref_held_pc = redirect_pc;
            end
        end
    end

    // --------------------------------------------------
    // Stimulus, driven on the falling edge
    // --------------------------------------------------
    task automatic wait_for_valid();
        int unsigned waited;
        waited = 0;
        while (!out_valid) begin
            if (waited == wait_limit) begin
                stop_on_error("Timed out waiting for out_valid from the DUT");
            end else begin
                @(negedge clock);
                waited++;
            end
        end
    endtask

    task automatic take_item(input int unsigned stall, input logic redirect,
                             input logic [31:0] target);
        wait_for_valid();
        repeat (stall) @(negedge clock);
        out_ready      = 1'b1;
        redirect_valid = redirect;
        redirect_pc    = target;
        @(negedge clock);
        out_ready      = 1'b0;
        redirect_valid = 1'b0;
        taken++;
    endtask

    initial begin
        void'($urandom(75575));
        clock          = 1'b0;
        reset          = 1'b1;
        redirect_pc    = '0;
        redirect_valid = 1'b0;
        clear_req      = 1'b0;
        out_ready      = 1'b0;
        taken          = 0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Straight run from the reset vector with random stalls
        for (int i = 0; i < 24; i++) begin
            take_item($urandom % 5, 1'b0, '0);
        end

        // Redirect in the accept cycle
        take_item(0, 1'b1, 32'h3000_0400);
        take_item(1, 1'b0, '0);

        // Redirect during a stall, applied at the next accept
        wait_for_valid();
        redirect_valid = 1'b1;
        redirect_pc    = 32'h3000_0800;
        @(negedge clock);
        redirect_valid = 1'b0;
        take_item(2, 1'b0, '0);
        take_item(0, 1'b0, '0);

        // Loop of line_count words: fill, hit, then refill after a clear
        take_item(0, 1'b1, loop_base);
        for (int pass = 0; pass < 3; pass++) begin
            pass_start = ar_count;
            for (int i = 0; i < line_count; i++) begin
                if (pass == 1 && i == line_count - 1) begin
                    wait_for_valid();
                    clear_req = 1'b1;
                    @(negedge clock);
                    clear_req = 1'b0;
                end
                take_item(0, i == line_count - 1 && pass < 2, loop_base);
            end
            want_handshakes = (pass == 1) ? 0 : line_count;
            if (ar_count - pass_start != want_handshakes) begin
                stop_on_error($sformatf("Loop pass %0d made %0d AR handshakes, expected %0d",
                                        pass, ar_count - pass_start, want_handshakes));
            end
        end

        if (accept_count != taken) begin
            stop_on_error("Number of accepted items differs from the number taken");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* verification/axi_mem_model.sv */
`timescale 1ns/1ns

module axi_mem_model (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       arvalid,
    input  logic [fetch_pkg::xlen-1:0] araddr,
    input  logic [3:0]                 arid,
    output logic                       arready,
    input  logic                       rready,
    output logic                       rvalid,
    output logic [fetch_pkg::xlen-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rlast,
    output logic [3:0]                 rid,
    // Word lookup served by the testbench
    output logic [fetch_pkg::xlen-1:0] lookup_addr,
    input  logic [fetch_pkg::xlen-1:0] lookup_data
);

    localparam logic [1:0] ph_idle = 2'd0;
    localparam logic [1:0] ph_addr = 2'd1;
    localparam logic [1:0] ph_data = 2'd2;

    logic [1:0]  phase;
    logic [3:0]  req_id;
    int unsigned wait_cycles;

    initial begin
        arready     = 1'b0;
        rvalid      = 1'b0;
        rdata       = '0;
        rresp       = 2'b00;
        rlast       = 1'b0;
        rid         = 4'd0;
        lookup_addr = '0;
        phase       = ph_idle;
        req_id      = 4'd0;
        wait_cycles = 0;
    end

    // --------------------------------------------------
    // Slave FSM, outputs change on the falling edge
    // --------------------------------------------------
    always @(negedge clock) begin
        if (reset) begin
            phase   = ph_idle;
            arready = 1'b0;
            rvalid  = 1'b0;
            rlast   = 1'b0;
        end else begin
            case (phase)
                ph_idle: begin
                    if (arvalid) begin
                        lookup_addr = araddr;
                        req_id      = arid;
                        wait_cycles = $urandom % 4;
                        phase       = ph_addr;
                    end
                end
                ph_addr: begin
                    if (arready) begin
                        // Address taken at the last rising edge
                        arready     = 1'b0;
                        wait_cycles = $urandom % 6;
                        phase       = ph_data;
                    end else if (wait_cycles == 0) begin
                        arready = 1'b1;
                    end else begin
                        wait_cycles--;
                    end
                end
                ph_data: begin
                    if (rvalid && rready) begin
                        rvalid = 1'b0;
                        rlast  = 1'b0;
                        phase  = ph_idle;
                    end else if (!rvalid && wait_cycles == 0) begin
                        // Single beat, always OKAY
                        rvalid = 1'b1;
                        rlast  = 1'b1;
                        rdata  = lookup_data;
                        rid    = req_id;
                        rresp  = 2'b00;
                    end else if (!rvalid) begin
                        wait_cycles--;
                    end
                end
                default: begin
                    phase = ph_idle;
                end
            endcase
        end
    end

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc   = fetch_pkg::reset_vector,
    parameter int                         line_count = 16
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,
    input  logic                       redirect_valid,
    input  logic                       clear_req,

    // AXI4 read address channel
    input  logic                       arready,
    output logic                       arvalid,
    output logic [fetch_pkg::xlen-1:0] araddr,
    output logic [3:0]                 arid,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,

    // AXI4 read data channel
    output logic                       rready,
    input  logic                       rvalid,
    input  logic [fetch_pkg::xlen-1:0] rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rlast,
    input  logic [3:0]                 rid,

    // Decoded instruction toward execute
    input  logic                       out_ready,
    output logic                       out_valid,
    output logic [fetch_pkg::xlen-1:0] pc,
    output logic [fetch_pkg::xlen-1:0] inst,
    output fetch_pkg::inst_format_t    format,
    output logic [6:0]                 opcode,
    output logic [4:0]                 rd,
    output logic [4:0]                 rs1,
    output logic [4:0]                 rs2,
    output logic [2:0]                 funct3,
    output logic [6:0]                 funct7,
    output logic [fetch_pkg::xlen-1:0] imm
);

    logic                       accept;
    logic                       fetch_req;
    logic [fetch_pkg::xlen-1:0] fetch_addr;
    logic                       cache_clear;
    logic                       fetch_done;
    logic [fetch_pkg::xlen-1:0] fetch_data;

    assign accept = out_valid && out_ready;

    fetch_pc_stage #(
        .reset_pc (reset_pc)
    ) pc_stage0 (
        .clock          (clock),
        .reset          (reset),
        .redirect_pc    (redirect_pc),
        .redirect_valid (redirect_valid),
        .clear_req      (clear_req),
        .accept         (accept),
        .fetch_done     (fetch_done),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .cache_clear    (cache_clear)
    );

    icache #(
        .line_count (line_count)
    ) icache0 (
        .clock       (clock),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .cache_clear (cache_clear),
        .fetch_done  (fetch_done),
        .fetch_data  (fetch_data),
        .arready     (arready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arid        (arid),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .rready      (rready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rid         (rid)
    );

    // The pc register still holds the address of the word in flight
    inst_decode_stage decode0 (
        .clock     (clock),
        .reset     (reset),
        .load      (fetch_done),
        .load_pc   (fetch_addr),
        .load_word (fetch_data),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .pc        (pc),
        .inst      (inst),
        .format    (format),
        .opcode    (opcode),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .funct3    (funct3),
        .funct7    (funct7),
        .imm       (imm)
    );

endmodule

/* verilog/inst_decode_stage.sv */
`timescale 1ns/1ns

module inst_decode_stage (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           load,
    input  logic [fetch_pkg::xlen-1:0]     load_pc,
    input  logic [fetch_pkg::xlen-1:0]     load_word,
    input  logic                           out_ready,
    output logic                           out_valid,
    output logic [fetch_pkg::xlen-1:0]     pc,
    output logic [fetch_pkg::xlen-1:0]     inst,
    output fetch_pkg::inst_format_t        format,
    output logic [6:0]                     opcode,
    output logic [4:0]                     rd,
    output logic [4:0]                     rs1,
    output logic [4:0]                     rs2,
    output logic [2:0]                     funct3,
    output logic [6:0]                     funct7,
    output logic [fetch_pkg::xlen-1:0]     imm
);

    fetch_pkg::inst_word_t      word_in;
    fetch_pkg::inst_word_t      word_q;
    fetch_pkg::inst_format_t    format_in;
    logic [fetch_pkg::xlen-1:0] imm_in;

    assign word_in = load_word;

    // --------------------------------------------------
    // Format from the major opcode
    // --------------------------------------------------
    always_comb begin
        case (word_in.r.opcode)
            fetch_pkg::op_lui, fetch_pkg::op_auipc: format_in = fetch_pkg::fmt_u;
            fetch_pkg::op_jal:                      format_in = fetch_pkg::fmt_j;
            fetch_pkg::op_branch:                   format_in = fetch_pkg::fmt_b;
            fetch_pkg::op_store:                    format_in = fetch_pkg::fmt_s;
            fetch_pkg::op_reg:                      format_in = fetch_pkg::fmt_r;
            default:                                format_in = fetch_pkg::fmt_i;
        endcase
    end

    // Sign-extended immediate per format
    always_comb begin
        case (format_in)
            fetch_pkg::fmt_i: imm_in = {{20{word_in.i.imm[11]}}, word_in.i.imm};
            fetch_pkg::fmt_s: imm_in = {{20{word_in.s.imm_hi[6]}}, word_in.s.imm_hi,
                                        word_in.s.imm_lo};
            fetch_pkg::fmt_b: imm_in = {{19{word_in.s.imm_hi[6]}}, word_in.s.imm_hi[6],
                                        word_in.s.imm_lo[0], word_in.s.imm_hi[5:0],
                                        word_in.s.imm_lo[4:1], 1'b0};
            fetch_pkg::fmt_u: imm_in = {word_in.u.imm, 12'd0};
            fetch_pkg::fmt_j: imm_in = {{11{word_in.u.imm[19]}}, word_in.u.imm[19],
                                        word_in.u.imm[7:0], word_in.u.imm[8],
                                        word_in.u.imm[18:9], 1'b0};
            default:          imm_in = '0;
        endcase
    end

    // --------------------------------------------------
    // Output register, held until out_ready
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            pc     <= load_pc;
            word_q <= word_in;
            format <= format_in;
            imm    <= imm_in;
        end
    end

    // Plain fields sit at the same place in every format
    assign inst   = word_q;
    assign opcode = word_q.r.opcode;
    assign rd     = word_q.r.rd;
    assign rs1    = word_q.r.rs1;
    assign rs2    = word_q.r.rs2;
    assign funct3 = word_q.r.funct3;
    assign funct7 = word_q.r.funct7;

endmodule

/* verilog/icache.sv */
`timescale 1ns/1ns

module icache #(
    parameter int line_count = 16
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       fetch_req,
    input  logic [fetch_pkg::xlen-1:0] fetch_addr,
    input  logic                       cache_clear,
    output logic                       fetch_done,
    output logic [fetch_pkg::xlen-1:0] fetch_data,

    input  logic                       arready,
    output logic                       arvalid,
    output logic [fetch_pkg::xlen-1:0] araddr,
    output logic [3:0]                 arid,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,

    output logic                       rready,
    input  logic                       rvalid,
    input  logic [fetch_pkg::xlen-1:0] rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rlast,
    input  logic [3:0]                 rid
);

    localparam int index_bits = $clog2(line_count);
    localparam int tag_bits   = fetch_pkg::xlen - index_bits - 2;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1;
    localparam logic [1:0] st_data = 2'd2;

    localparam logic [3:0] read_id = 4'd0;

    logic [1:0]                 state;
    logic [line_count-1:0]      line_valid;
    logic [tag_bits-1:0]        tag_mem  [line_count];
    logic [fetch_pkg::xlen-1:0] data_mem [line_count];

    logic [index_bits-1:0]      req_index;
    logic [tag_bits-1:0]        req_tag;
    logic [index_bits-1:0]      fill_index;
    logic [tag_bits-1:0]        fill_tag;
    logic                       hit;
    logic                       lookup;
    logic                       resp_done;

    // --------------------------------------------------
    // Lookup on the word address
    // --------------------------------------------------
    assign req_index  = fetch_addr[index_bits+1:2];
    assign req_tag    = fetch_addr[fetch_pkg::xlen-1:index_bits+2];
    assign fill_index = araddr[index_bits+1:2];
    assign fill_tag   = araddr[fetch_pkg::xlen-1:index_bits+2];

    // A pending clear forces the lookup to miss
    assign hit = line_valid[req_index] && (tag_mem[req_index] == req_tag) && !cache_clear;

    assign lookup    = (state == st_idle) && fetch_req;
    assign resp_done = rvalid && rlast && (rid == read_id);

    // Single beat, 4 bytes, fixed burst
    assign arid    = read_id;
    assign arlen   = 8'd0;
    assign arsize  = 3'b010;
    assign arburst = 2'b00;
    assign rready  = 1'b1;

    // --------------------------------------------------
    // Miss FSM and valid bits
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= st_idle;
            arvalid    <= 1'b0;
            fetch_done <= 1'b0;
            line_valid <= '0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (fetch_req && hit) begin
                        fetch_done <= 1'b1;
                    end else if (fetch_req) begin
                        arvalid <= 1'b1;
                        state   <= st_addr;
                    end
                end
                st_addr: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= st_data;
                    end
                end
                st_data: begin
                    if (resp_done) begin
                        fetch_done <= 1'b1;
                        state      <= st_idle;
                        // Only an OKAY response makes the line usable
                        if (!rresp[1]) begin
                            line_valid[fill_index] <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
            if (fetch_done && cache_clear) begin
                line_valid <= '0;
            end
        end
    end

    // --------------------------------------------------
    // Storage and returned word
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (lookup) begin
            fetch_data <= data_mem[req_index];
            if (!hit) begin
                araddr <= fetch_addr;
            end
        end
        if ((state == st_data) && resp_done) begin
            fetch_data           <= rdata;
            data_mem[fill_index] <= rdata;
            tag_mem[fill_index]  <= fill_tag;
        end
    end

endmodule

/* verilog/fetch_pc_stage.sv */
`timescale 1ns/1ns

module fetch_pc_stage #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc = fetch_pkg::reset_vector
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,
    input  logic                       redirect_valid,
    input  logic                       clear_req,
    input  logic                       accept,
    input  logic                       fetch_done,
    output logic                       fetch_req,
    output logic [fetch_pkg::xlen-1:0] fetch_addr,
    output logic                       cache_clear
);

    logic                       booted;
    logic                       held_valid;
    logic [fetch_pkg::xlen-1:0] held_pc;
    logic                       clear_held;
    logic [fetch_pkg::xlen-1:0] next_pc;
    logic                       capture;

    // --------------------------------------------------
    // Next pc selection
    // --------------------------------------------------
    always_comb begin
        if (held_valid) begin
            next_pc = held_pc;
        end else if (redirect_valid) begin
            next_pc = redirect_pc;
        end else begin
            next_pc = fetch_addr + 32'd4;
        end
    end

    // Redirect seen while stalled, first one wins
    assign capture = redirect_valid && !held_valid && !accept;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            booted     <= 1'b0;
            fetch_req  <= 1'b0;
            fetch_addr <= reset_pc;
            held_valid <= 1'b0;
        end else begin
            // One strobe out of reset, then one per accepted item
            booted    <= 1'b1;
            fetch_req <= !booted || accept;
            if (accept) begin
                fetch_addr <= next_pc;
                held_valid <= 1'b0;
            end else if (capture) begin
                held_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            held_pc <= redirect_pc;
        end
    end

    // --------------------------------------------------
    // Cache clear, kept until the next fetch completes
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            clear_held <= 1'b0;
        end else if (fetch_done) begin
            clear_held <= 1'b0;
        end else if (clear_req) begin
            clear_held <= 1'b1;
        end
    end

    assign cache_clear = clear_held || clear_req;

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    localparam int xlen = 32;

    localparam logic [xlen-1:0] reset_vector = 32'h3000_0000;

    // --------------------------------------------------
    // RV32I major opcodes
    // --------------------------------------------------
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } inst_format_t;

    // --------------------------------------------------
    // Field layouts, msb first
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_form_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_form_t;

    // Also the B layout, with the immediate bits scrambled
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_form_t;

    // Also the J layout
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_form_t;

    typedef union packed {
        r_form_t r;
        i_form_t i;
        s_form_t s;
        u_form_t u;
    } inst_word_t;

endpackage
